// ==== bench/fe_checker.sv ====
// Diagnostic bus scoreboard
`default_nettype none
`timescale 1ns/1ps

module fe_checker (
  input wire                                  clk,
  input wire                                  wb_ack,
  input wire                                  wb_we,
  input wire [7:0]                            wb_dat_o,
  input var fe_diag_pkg::diag_func_e          diag_func,
  input var fe_diag_pkg::diag_data_t          diag_data,
  input wire                                  diag_strobe,
  input wire [fe_diag_pkg::LINE_CNT_W-1:0]    lines_ok,
  input wire [fe_diag_pkg::LINE_CNT_W-1:0]    lines_bad
);
  import fe_diag_pkg::*;

  // Expected writes in bus order, filled by the reference model
  diag_func_e exp_func[$];
  diag_data_t exp_data[$];

  diag_func_e want_func;
  diag_data_t want_data;
  logic       strobe_d;

  // Clocks spent in the current strobe phase
  int high_cnt;
  int low_cnt;

  // Error and test tallies
  int err_cnt;
  int test_err_base;
  int n_pass;
  int n_fail;

  initial begin
    strobe_d      = 1'b0;
    high_cnt      = 0;
    low_cnt       = DIAG_GAP_CYCLES;
    err_cnt       = 0;
    test_err_base = 0;
    n_pass        = 0;
    n_fail        = 0;
  end

  //////////////////////////////////////////////////
  // Queue access
  //////////////////////////////////////////////////

  function automatic void expect_write(input diag_func_e f, input diag_data_t d);
    exp_func.push_back(f);
    exp_data.push_back(d);
  endfunction

  function automatic int pending();
    return exp_func.size();
  endfunction

  //////////////////////////////////////////////////
  // Host read data
  //////////////////////////////////////////////////

  // Reads are acked with zero data
  always @(negedge clk) begin
    if (wb_ack === 1'b1 && wb_we === 1'b0 && wb_dat_o !== 8'h00) begin
      $display("FAILED wb_dat_o: got 0x%02h expected 0x%02h", wb_dat_o, 8'h00);
      err_cnt++;
    end
  end

  //////////////////////////////////////////////////
  // Write compare
  //////////////////////////////////////////////////

  // Sampled mid cycle, one compare per strobe rise
  always @(negedge clk) begin
    if (diag_strobe === 1'b1 && strobe_d !== 1'b1) begin
      if (low_cnt < DIAG_GAP_CYCLES) begin
        $display("FAILED diag_strobe low time: got 0x%0h expected at least 0x%0h",
                 low_cnt, DIAG_GAP_CYCLES);
        err_cnt++;
      end
      high_cnt = 0;
      if (exp_func.size() == 0) begin
        $display("extra write on the diagnostic bus, function 0x%02h data 0x%09h",
                 diag_func, diag_data);
        err_cnt++;
      end else begin
        want_func = exp_func.pop_front();
        want_data = exp_data.pop_front();
        if (diag_func !== want_func) begin
          $display("FAILED diag_func: got 0x%02h expected 0x%02h", diag_func, want_func);
          err_cnt++;
        end
        if (diag_data !== want_data) begin
          $display("FAILED diag_data: got 0x%09h expected 0x%09h", diag_data, want_data);
          err_cnt++;
        end
      end
    end
    // Strobe high time of the write that just ended
    if (diag_strobe !== 1'b1 && strobe_d === 1'b1) begin
      if (high_cnt != DIAG_HOLD_CYCLES) begin
        $display("FAILED diag_strobe high time: got 0x%0h expected 0x%0h",
                 high_cnt, DIAG_HOLD_CYCLES);
        err_cnt++;
      end
      low_cnt = 0;
    end
    if (diag_strobe === 1'b1) begin
      high_cnt++;
    end else begin
      low_cnt++;
    end
    strobe_d = diag_strobe;
  end

  //////////////////////////////////////////////////
  // End of test
  //////////////////////////////////////////////////

  task automatic end_test(input int num, input string name, input int exp_ok,
                          input int exp_bad);
    if (exp_func.size() != 0) begin
      $display("%0d expected writes never appeared on the diagnostic bus", exp_func.size());
      err_cnt++;
      exp_func.delete();
      exp_data.delete();
    end
    if (lines_ok !== LINE_CNT_W'(exp_ok)) begin
      $display("FAILED lines_ok: got 0x%02h expected 0x%02h", lines_ok, LINE_CNT_W'(exp_ok));
      err_cnt++;
    end
    if (lines_bad !== LINE_CNT_W'(exp_bad)) begin
      $display("FAILED lines_bad: got 0x%02h expected 0x%02h", lines_bad,
               LINE_CNT_W'(exp_bad));
      err_cnt++;
    end
    if (err_cnt == test_err_base) begin
      n_pass++;
      $display("test %0d %s: ok, lines_ok %0d lines_bad %0d", num, name, lines_ok, lines_bad);
    end else begin
      n_fail++;
      $display("test %0d %s: %0d errors", num, name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

endmodule

`default_nettype wire

// ==== bench/tb_fe_loader.sv ====
// Microcode loader testbench
`default_nettype none
`timescale 1ns/1ps

module tb_fe_loader;
  import fe_file_pkg::*;
  import fe_diag_pkg::*;

  logic                  clk;
  logic                  rst_n;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [7:0]            wb_dat_i;
  logic                  wb_ack;
  logic [7:0]            wb_dat_o;
  diag_func_e            diag_func;
  diag_data_t            diag_data;
  logic                  diag_strobe;
  logic [LINE_CNT_W-1:0] lines_ok;
  logic [LINE_CNT_W-1:0] lines_bad;

  // Running expectations
  int exp_ok;
  int exp_bad;
  int ref_writes;
  int test_num;

  // Watchdog and host pacing
  int cycles;
  int cycle_limit;
  int max_gap;

  // Line under construction, as words and as characters
  word16_t    dq[$];
  word16_t    lw[$];
  logic [7:0] line_q[$];

  fe_loader DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_dat_i    (wb_dat_i),
    .wb_ack      (wb_ack),
    .wb_dat_o    (wb_dat_o),
    .diag_func   (diag_func),
    .diag_data   (diag_data),
    .diag_strobe (diag_strobe),
    .lines_ok    (lines_ok),
    .lines_bad   (lines_bad)
  );

  fe_checker CHK (
    .clk         (clk),
    .wb_ack      (wb_ack),
    .wb_we       (wb_we),
    .wb_dat_o    (wb_dat_o),
    .diag_func   (diag_func),
    .diag_data   (diag_data),
    .diag_strobe (diag_strobe),
    .lines_ok    (lines_ok),
    .lines_bad   (lines_bad)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the loader stopped making progress", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Load file encoding
  //////////////////////////////////////////////////

  // Fields below 075 octal move up by 0100 octal
  function automatic logic [7:0] field_char(input logic [5:0] f);
    if (f < 6'o75) begin
      return {2'b01, f};
    end
    return {2'b00, f};
  endfunction

  // Leading zero fields dropped unless full width is asked for
  task automatic put_word(input word16_t w, input bit full);
    logic [5:0] f[3];
    bit         lead;
    f[0] = {2'b00, w[15:12]};
    f[1] = w[11:6];
    f[2] = w[5:0];
    lead = !full;
    for (int i = 0; i < 3; i++) begin
      if (!(lead && f[i] == 6'd0)) begin
        line_q.push_back(field_char(f[i]));
        lead = 1'b0;
      end
    end
  endtask

  // Word count, address, data and the negated sum
  task automatic frame_line(input word16_t wc, input word16_t adr, input word16_t data[$]);
    word16_t s;
    lw.delete();
    lw.push_back(wc);
    lw.push_back(adr);
    foreach (data[i]) begin
      lw.push_back(data[i]);
    end
    s = '0;
    foreach (lw[i]) begin
      s = s + lw[i];
    end
    lw.push_back(-s);
  endtask

  function automatic rec_kind_e kind_of(input logic [7:0] ch);
    case (ch)
      "C":     return REC_C;
      "D":     return REC_D;
      "Z":     return REC_Z;
      default: return REC_OTHER;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic diag_func_e data_func(input bit is_dram, input int k);
    if (is_dram) begin
      case (k)
        0:       return DF_DRAM_EVEN;
        1:       return DF_DRAM_ODD;
        default: return DF_DRAM_COMMON;
      endcase
    end
    case (k)
      0:       return DF_CRAM_W0;
      1:       return DF_CRAM_W1;
      2:       return DF_CRAM_W2;
      3:       return DF_CRAM_W3;
      4:       return DF_CRAM_W4;
      default: return DF_CRAM_W5;
    endcase
  endfunction

  // Queues the writes of one line, returns 0 ok, 1 bad, 2 not counted
  function automatic int ref_line(input rec_kind_e kind, input word16_t w[$]);
    word16_t     s;
    int          grp;
    int          ndata;
    bit          dram;
    logic [10:0] adr;
    if (kind == REC_Z || w[0] == 16'h0000) begin
      return 2;
    end
    s = '0;
    foreach (w[i]) begin
      s = s + w[i];
    end
    ndata = w.size() - 3;
    dram  = (kind == REC_D);
    if (kind == REC_C || kind == REC_D) begin
      grp = dram ? DRAM_WORDS_PER_ENTRY : CRAM_WORDS_PER_ENTRY;
      adr = dram ? {3'b000, w[1][7:0]} : w[1][10:0];
      // Only full groups become entries
      for (int e = 0; e < ndata / grp; e++) begin
        CHK.expect_write(dram ? DF_DRAM_ADR : DF_CRAM_ADR, diag_data_t'(adr));
        for (int k = 0; k < grp; k++) begin
          CHK.expect_write(data_func(dram, k), diag_data_t'(w[2 + e * grp + k]));
        end
        ref_writes = ref_writes + grp + 1;
        // DRAM steps over a location pair inside 8 bits
        adr = dram ? {3'b000, adr[7:0] + 8'd2} : adr + 11'd1;
      end
    end
    return (s != 16'h0000 || ndata != int'(w[0]) || kind == REC_OTHER) ? 1 : 0;
  endfunction

  //////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////

  // One Wishbone write, entered and left on a falling edge
  task automatic host_write(input logic [7:0] ch);
    int gap;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_dat_i = ch;
    do begin
      @(negedge clk);
    end while (wb_ack !== 1'b1);
    // Request stays up through the ack cycle
    @(negedge clk);
    gap = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
    if (gap > 0) begin
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      repeat (gap) @(negedge clk);
    end
  endtask

  // One Wishbone read, the data bus must not reach the decoder
  task automatic host_read();
    cycle_limit = cycle_limit + 64;
    wb_cyc      = 1'b1;
    wb_stb      = 1'b1;
    wb_we       = 1'b0;
    wb_dat_i    = 8'hFF;
    do begin
      @(negedge clk);
    end while (wb_ack !== 1'b1);
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // Line from the current word list, through the model and onto the port
  task automatic send_line(input logic [7:0] tch, input bit full, input bit crlf);
    int st;
    int w0;
    w0 = ref_writes;
    line_q.delete();
    line_q.push_back(tch);
    line_q.push_back(" ");
    foreach (lw[i]) begin
      if (i > 0) begin
        line_q.push_back(CHAR_COMMA);
      end
      put_word(lw[i], full);
    end
    if (crlf) begin
      line_q.push_back(CHAR_CR);
    end
    line_q.push_back(CHAR_NEWLINE);
    st = ref_line(kind_of(tch), lw);
    if (st == 0) begin
      exp_ok++;
    end else if (st == 1) begin
      exp_bad++;
    end
    cycle_limit = cycle_limit + 64 * line_q.size() + 8 * (ref_writes - w0);
    foreach (line_q[i]) begin
      host_write(line_q[i]);
    end
  endtask

  // Raw text such as a comment line
  task automatic send_text(input string s);
    cycle_limit = cycle_limit + 64 * s.len();
    for (int i = 0; i < s.len(); i++) begin
      host_write(s[i]);
    end
  endtask

  // Drain the pipeline, then score the test
  task automatic finish_test(input string name);
    int waited;
    waited = 0;
    while (waited < 2000 && !(CHK.pending() == 0 && diag_strobe !== 1'b1 &&
           lines_ok == LINE_CNT_W'(exp_ok) && lines_bad == LINE_CNT_W'(exp_bad))) begin
      @(negedge clk);
      waited++;
    end
    test_num++;
    CHK.end_test(test_num, name, exp_ok, exp_bad);
  endtask

  task automatic random_lines(input int n);
    logic [7:0] tch;
    int         grp;
    int         n_ent;
    word16_t    adr;
    for (int i = 0; i < n; i++) begin
      tch   = ($urandom % 2 == 0) ? "C" : "D";
      grp   = (tch == "D") ? DRAM_WORDS_PER_ENTRY : CRAM_WORDS_PER_ENTRY;
      n_ent = 1 + int'($urandom % 3);
      adr   = (tch == "D") ? word16_t'($urandom % 256) : word16_t'($urandom % 2048);
      dq.delete();
      repeat (n_ent * grp) dq.push_back(word16_t'($urandom));
      frame_line(word16_t'(n_ent * grp), adr, dq);
      // Now and then a broken checksum
      if ($urandom % 6 == 0) begin
        lw[lw.size() - 1] = lw[lw.size() - 1] ^ 16'h0040;
      end
      send_line(tch, bit'($urandom % 2), 1'b0);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(86617));
    clk         = 1'b0;
    rst_n       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_dat_i    = 8'h00;
    exp_ok      = 0;
    exp_bad     = 0;
    ref_writes  = 0;
    test_num    = 0;
    cycles      = 0;
    cycle_limit = 1000;
    max_gap     = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // Single CRAM entry
    dq.delete();
    dq.push_back(16'h1234);
    dq.push_back(16'hBEEF);
    dq.push_back(16'h0001);
    dq.push_back(16'h8000);
    dq.push_back(16'h0FC0);
    dq.push_back(16'h003F);
    frame_line(16'd6, 16'h0123, dq);
    send_line("C", 1'b0, 1'b0);
    finish_test("cram single entry");

    // Three entries with high fields and empty fields, address wraps
    max_gap = 1;
    dq.delete();
    for (int i = 0; i < 18; i++) begin
      case (i % 4)
        0:       dq.push_back(16'h0000);
        1:       dq.push_back({4'(i), 6'o75, 6'o77});
        2:       dq.push_back({4'hF, 6'o76, 6'(i)});
        default: dq.push_back({4'h0, 6'o77, 6'o75});
      endcase
    end
    frame_line(16'd18, 16'h07FF, dq);
    send_line("C", 1'b0, 1'b0);
    finish_test("cram fields and stepping");

    // Two DRAM pairs
    dq.delete();
    for (int i = 0; i < 6; i++) begin
      dq.push_back(16'h1111 * (i + 1));
    end
    frame_line(16'd6, 16'h007E, dq);
    send_line("D", 1'b1, 1'b0);
    finish_test("dram pairs");

    // Bad lines still write, skipped lines and host reads do nothing
    send_text(";comment, with a comma\n");
    host_read();
    dq.delete();
    for (int i = 0; i < 6; i++) begin
      dq.push_back(16'hA5A0 + i);
    end
    frame_line(16'd6, 16'h0200, dq);
    lw[lw.size() - 1] = lw[lw.size() - 1] ^ 16'h0101;
    send_line("C", 1'b0, 1'b0);
    host_read();
    dq.delete();
    dq.push_back(16'o5);
    frame_line(16'd3, 16'o200, dq);
    send_line("Z", 1'b0, 1'b1);
    dq.delete();
    for (int i = 0; i < 6; i++) begin
      dq.push_back(16'h0F00 + i);
    end
    frame_line(16'd7, 16'h0300, dq);
    send_line("C", 1'b0, 1'b0);
    dq.delete();
    frame_line(16'd0, 16'd0, dq);
    send_line("D", 1'b0, 1'b0);
    finish_test("bad and skipped lines");

    // Random lines with random host gaps
    max_gap = 3;
    random_lines(20);
    finish_test("random lines");

    $display("tests passed %0d, tests failed %0d", CHK.n_pass, CHK.n_fail);
    if (CHK.n_fail == 0 && CHK.err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== fe_loader.f ====
hdl/fe_file_pkg.sv
hdl/fe_diag_pkg.sv
hdl/fe_word_if.sv
hdl/fe_entry_if.sv
hdl/asciiz_decoder.sv
hdl/record_parser.sv
hdl/diag_writer.sv
hdl/fe_loader.sv
bench/fe_checker.sv
bench/tb_fe_loader.sv

// ==== hdl/asciiz_decoder.sv ====
// Load file character decoder
`default_nettype none
`timescale 1ns/1ps

module asciiz_decoder (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        wb_cyc,
  input  wire        wb_stb,
  input  wire        wb_we,
  input  wire  [7:0] wb_dat_i,
  output logic       wb_ack,
  output logic [7:0] wb_dat_o,
  fe_word_if.source  words
);
  import fe_file_pkg::*;

  // Position within the current line
  typedef enum logic [1:0] {
    D_LINE_START,
    D_AFTER_TYPE,
    D_FIELDS,
    D_COMMENT
  } dstate_e;

  dstate_e    state;
  rec_kind_e  line_kind;
  rec_kind_e  type_kind;
  word16_t    acc;
  logic       first_pend;
  logic       hold_vld;
  logic [7:0] hold_char;
  logic       in_delim;
  logic       req_ok;
  logic       is_delim;
  logic       emit;

  //////////////////////////////////////////////////
  // Wishbone slave
  //////////////////////////////////////////////////

  // Incoming write that would close a field
  assign in_delim = wb_we && (wb_dat_i == CHAR_COMMA || wb_dat_i == CHAR_NEWLINE);

  // No back to back acks, and hold off a delimiter until the word register drains
  assign req_ok = wb_cyc && wb_stb && !wb_ack && !(in_delim && words.valid);

  // Reads return zero
  assign wb_dat_o = 8'h00;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack   <= 1'b0;
      hold_vld <= 1'b0;
    end else begin
      wb_ack   <= req_ok;
      hold_vld <= req_ok && wb_we;
    end
  end

  // Holding stage, decoded during the ack cycle
  always_ff @(posedge clk) begin
    if (req_ok) begin
      hold_char <= wb_dat_i;
    end
  end

  //////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////

  assign is_delim = (hold_char == CHAR_COMMA) || (hold_char == CHAR_NEWLINE);
  assign emit     = hold_vld && (state == D_FIELDS) && is_delim;

  always_comb begin
    unique case (hold_char)
      "C":     type_kind = REC_C;
      "D":     type_kind = REC_D;
      "Z":     type_kind = REC_Z;
      default: type_kind = REC_OTHER;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= D_LINE_START;
      acc         <= '0;
      first_pend  <= 1'b0;
      words.valid <= 1'b0;
    end else begin
      if (words.valid && words.ready) begin
        words.valid <= 1'b0;
      end
      // Carriage returns never change anything
      if (hold_vld && hold_char != CHAR_CR) begin
        unique case (state)
          D_LINE_START: begin
            if (hold_char == CHAR_COMMENT) begin
              state <= D_COMMENT;
            end else if (hold_char != CHAR_NEWLINE) begin
              state      <= D_AFTER_TYPE;
              first_pend <= 1'b1;
              acc        <= '0;
            end
          end
          // Separator after the type letter
          D_AFTER_TYPE: begin
            state <= (hold_char == CHAR_NEWLINE) ? D_LINE_START : D_FIELDS;
          end
          D_FIELDS: begin
            if (is_delim) begin
              words.valid <= 1'b1;
              first_pend  <= 1'b0;
              acc         <= '0;
              if (hold_char == CHAR_NEWLINE) begin
                state <= D_LINE_START;
              end
            end else begin
              // Most significant field arrives first
              acc <= word16_t'({acc, hold_char[FIELD_BITS-1:0]});
            end
          end
          default: begin
            if (hold_char == CHAR_NEWLINE) begin
              state <= D_LINE_START;
            end
          end
        endcase
      end
    end
  end

  // Word payload and line type
  always_ff @(posedge clk) begin
    if (hold_vld && state == D_LINE_START) begin
      line_kind <= type_kind;
    end
    if (emit) begin
      words.word  <= acc;
      words.kind  <= line_kind;
      words.first <= first_pend;
      words.last  <= (hold_char == CHAR_NEWLINE);
    end
  end

  // Host must keep the request up through the ack
  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> (wb_cyc && wb_stb));

endmodule

`default_nettype wire

// ==== hdl/diag_writer.sv ====
// Diagnostic bus RAM writer
`default_nettype none
`timescale 1ns/1ps

module diag_writer (
  input  wire                      clk,
  input  wire                      rst_n,
  fe_entry_if.sink                 entries,
  output fe_diag_pkg::diag_func_e  diag_func,
  output fe_diag_pkg::diag_data_t  diag_data,
  output logic                     diag_strobe
);
  import fe_file_pkg::*;
  import fe_diag_pkg::*;

  typedef enum logic [1:0] {
    W_IDLE,
    W_STROBE,
    W_GAP
  } wstate_e;

  wstate_e                            state;
  logic [DIAG_CNT_W-1:0]              cnt;
  logic [2:0]                         widx;
  logic [2:0]                         wlast;
  logic                               e_dram;
  logic [CRAM_ADDR_W-1:0]             e_addr;
  word16_t [CRAM_WORDS_PER_ENTRY-1:0] e_data;

  // One entry at a time
  assign entries.ready = (state == W_IDLE);
  assign diag_strobe   = (state == W_STROBE);

  // Address write plus one write per data word
  assign wlast = e_dram ? 3'(DRAM_WORDS_PER_ENTRY) : 3'(CRAM_WORDS_PER_ENTRY);

  //////////////////////////////////////////////////
  // Write list
  //////////////////////////////////////////////////

  always_comb begin
    if (widx == 3'd0) begin
      diag_data = diag_data_t'(e_addr);
    end else begin
      diag_data = diag_data_t'(e_data[widx - 3'd1]);
    end
    unique case (widx)
      3'd0:    diag_func = e_dram ? DF_DRAM_ADR    : DF_CRAM_ADR;
      3'd1:    diag_func = e_dram ? DF_DRAM_EVEN   : DF_CRAM_W0;
      3'd2:    diag_func = e_dram ? DF_DRAM_ODD    : DF_CRAM_W1;
      3'd3:    diag_func = e_dram ? DF_DRAM_COMMON : DF_CRAM_W2;
      3'd4:    diag_func = DF_CRAM_W3;
      3'd5:    diag_func = DF_CRAM_W4;
      default: diag_func = DF_CRAM_W5;
    endcase
  end

  //////////////////////////////////////////////////
  // Strobe timing
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= W_IDLE;
      cnt   <= '0;
      widx  <= '0;
    end else begin
      unique case (state)
        W_IDLE: begin
          if (entries.valid) begin
            state <= W_STROBE;
            cnt   <= '0;
            widx  <= '0;
          end
        end
        W_STROBE: begin
          if (cnt == DIAG_CNT_W'(DIAG_HOLD_CYCLES - 1)) begin
            state <= W_GAP;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          if (cnt == DIAG_CNT_W'(DIAG_GAP_CYCLES - 1)) begin
            cnt <= '0;
            // Done after the last word of the entry
            if (widx == wlast) begin
              state <= W_IDLE;
            end else begin
              widx  <= widx + 1'b1;
              state <= W_STROBE;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Entry latch
  always_ff @(posedge clk) begin
    if (entries.valid && entries.ready) begin
      e_dram <= entries.is_dram;
      e_addr <= entries.addr;
      e_data <= entries.data;
    end
  end

  // Function and data hold for the whole strobe
  a_bus_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (diag_strobe ##1 diag_strobe) |-> ($stable(diag_func) && $stable(diag_data)));

endmodule

`default_nettype wire

// ==== hdl/fe_diag_pkg.sv ====
// Diagnostic bus definitions
`default_nettype none

package fe_diag_pkg;

  // Diagnostic function codes
  typedef enum logic [6:0] {
    DF_CRAM_W0     = 7'o051,
    DF_CRAM_W1     = 7'o052,
    DF_CRAM_W2     = 7'o053,
    DF_CRAM_W3     = 7'o054,
    DF_CRAM_W4     = 7'o055,
    DF_CRAM_W5     = 7'o056,
    DF_CRAM_ADR    = 7'o057,
    DF_DRAM_EVEN   = 7'o060,
    DF_DRAM_ODD    = 7'o061,
    DF_DRAM_COMMON = 7'o062,
    DF_DRAM_ADR    = 7'o075
  } diag_func_e;

  // One EBUS word
  typedef logic [35:0] diag_data_t;

  // Strobe high time and the low time after it, in clocks
  localparam int DIAG_HOLD_CYCLES = 4;
  localparam int DIAG_GAP_CYCLES  = 1;

  // Timing counter width, covers the longer of the two phases
  localparam int DIAG_CNT_W = $clog2(DIAG_HOLD_CYCLES) + 1;

  // Good and bad line counters
  localparam int LINE_CNT_W = 8;

endpackage

`default_nettype wire

// ==== hdl/fe_entry_if.sv ====
// RAM entry channel
`default_nettype none
`timescale 1ns/1ps

interface fe_entry_if;
  import fe_file_pkg::*;

  // DRAM pair when set, CRAM word otherwise
  logic is_dram;

  // DRAM uses the low bits only
  logic [CRAM_ADDR_W-1:0] addr;

  // Slot 0 holds the first file word of the group
  word16_t [CRAM_WORDS_PER_ENTRY-1:0] data;

  // Handshake
  logic valid;
  logic ready;

  modport source (
    output is_dram, addr, data, valid,
    input  ready
  );

  modport sink (
    input  is_dram, addr, data, valid,
    output ready
  );

endinterface

`default_nettype wire

// ==== hdl/fe_file_pkg.sv ====
// Microcode load file format
`default_nettype none

package fe_file_pkg;

  //////////////////////////////////////////////////
  // Words and record types
  //////////////////////////////////////////////////

  // One decoded file word
  typedef logic [15:0] word16_t;

  // Record type from the first character of a line
  typedef enum logic [1:0] {
    REC_C     = 2'd0,
    REC_D     = 2'd1,
    REC_Z     = 2'd2,
    REC_OTHER = 2'd3
  } rec_kind_e;

  // File words per RAM entry
  localparam int CRAM_WORDS_PER_ENTRY = 6;
  // Even, odd and common word per location pair
  localparam int DRAM_WORDS_PER_ENTRY = 3;

  // RAM address widths
  localparam int CRAM_ADDR_W = 11;
  localparam int DRAM_ADDR_W = 8;

  //////////////////////////////////////////////////
  // Characters
  //////////////////////////////////////////////////

  localparam logic [7:0] CHAR_COMMENT = 8'h3B;
  localparam logic [7:0] CHAR_COMMA   = 8'h2C;
  localparam logic [7:0] CHAR_NEWLINE = 8'h0A;
  localparam logic [7:0] CHAR_CR      = 8'h0D;

  // Payload bits carried by one character
  localparam int FIELD_BITS = 6;

endpackage

`default_nettype wire

// ==== hdl/fe_loader.sv ====
// Front end microcode loader
`default_nettype none
`timescale 1ns/1ps

module fe_loader (
  input  wire                                 clk,
  input  wire                                 rst_n,
  // Host character port
  input  wire                                 wb_cyc,
  input  wire                                 wb_stb,
  input  wire                                 wb_we,
  input  wire  [7:0]                          wb_dat_i,
  output logic                                wb_ack,
  output logic [7:0]                          wb_dat_o,
  // Diagnostic bus
  output fe_diag_pkg::diag_func_e             diag_func,
  output fe_diag_pkg::diag_data_t             diag_data,
  output logic                                diag_strobe,
  // Line status
  output logic [fe_diag_pkg::LINE_CNT_W-1:0]  lines_ok,
  output logic [fe_diag_pkg::LINE_CNT_W-1:0]  lines_bad
);

  fe_word_if  word_bus ();
  fe_entry_if entry_bus ();

  // Characters in, file words out
  asciiz_decoder u_decoder (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack),
    .wb_dat_o (wb_dat_o),
    .words    (word_bus.source)
  );

  // Words into RAM entries and line counts
  record_parser u_parser (
    .clk       (clk),
    .rst_n     (rst_n),
    .words     (word_bus.sink),
    .entries   (entry_bus.source),
    .lines_ok  (lines_ok),
    .lines_bad (lines_bad)
  );

  // Entries onto the diagnostic bus
  diag_writer u_writer (
    .clk         (clk),
    .rst_n       (rst_n),
    .entries     (entry_bus.sink),
    .diag_func   (diag_func),
    .diag_data   (diag_data),
    .diag_strobe (diag_strobe)
  );

endmodule

`default_nettype wire

// ==== hdl/fe_word_if.sv ====
// Decoded file word channel
`default_nettype none
`timescale 1ns/1ps

interface fe_word_if;
  import fe_file_pkg::*;

  // Word value and the type of its line
  word16_t   word;
  rec_kind_e kind;

  // First word of a line
  logic first;
  // Word was closed by a newline
  logic last;

  // Handshake
  logic valid;
  logic ready;

  modport source (
    output word, kind, first, last, valid,
    input  ready
  );

  modport sink (
    input  word, kind, first, last, valid,
    output ready
  );

endinterface

`default_nettype wire

// ==== hdl/record_parser.sv ====
// Load file record parser
`default_nettype none
`timescale 1ns/1ps

module record_parser (
  input  wire                                   clk,
  input  wire                                   rst_n,
  fe_word_if.sink                               words,
  fe_entry_if.source                            entries,
  output logic [fe_diag_pkg::LINE_CNT_W-1:0]    lines_ok,
  output logic [fe_diag_pkg::LINE_CNT_W-1:0]    lines_bad
);
  import fe_file_pkg::*;

  // Field position within a line, the checksum is whichever word carries last
  typedef enum logic [1:0] {
    P_WC,
    P_ADR,
    P_DATA
  } pstate_e;

  pstate_e                state;
  pstate_e                cur_state;
  word16_t                sum;
  word16_t                sum_next;
  word16_t                wc;
  word16_t                ndata;
  logic [CRAM_ADDR_W-1:0] addr;
  logic [CRAM_ADDR_W-1:0] addr_next;
  logic [2:0]             slot;
  logic [2:0]             grp_last;
  logic                   xfer;
  logic                   packs;
  logic                   grp_done;
  logic                   line_end;
  logic                   line_skip;
  logic                   line_bad;

  //////////////////////////////////////////////////
  // Word handshake
  //////////////////////////////////////////////////

  // Stall words while an entry waits for the writer
  assign words.ready = !entries.valid;
  assign xfer        = words.valid && words.ready;

  // A first word always restarts the line
  assign cur_state = words.first ? P_WC : state;

  // Running sum over every word of the line
  assign sum_next = (words.first ? word16_t'(0) : sum) + words.word;

  //////////////////////////////////////////////////
  // Entry grouping
  //////////////////////////////////////////////////

  assign packs    = (words.kind == REC_C) || (words.kind == REC_D);
  assign grp_last = (words.kind == REC_D) ? 3'(DRAM_WORDS_PER_ENTRY - 1)
                                          : 3'(CRAM_WORDS_PER_ENTRY - 1);
  assign grp_done = xfer && !words.last && (cur_state == P_DATA) && packs &&
                    (slot == grp_last);

  // DRAM steps over a location pair and stays inside its 8 bits
  assign addr_next = (words.kind == REC_D) ?
                     {{(CRAM_ADDR_W - DRAM_ADDR_W){1'b0}},
                      DRAM_ADDR_W'(addr[DRAM_ADDR_W-1:0] + DRAM_ADDR_W'(2))} :
                     addr + 1'b1;

  //////////////////////////////////////////////////
  // Line check
  //////////////////////////////////////////////////

  assign line_end = xfer && words.last;

  // Section end lines and Z lines are not counted
  assign line_skip = (words.kind == REC_Z) || ((cur_state != P_WC) && (wc == '0));

  assign line_bad = (sum_next != '0) || (ndata != wc) || (words.kind == REC_OTHER) ||
                    (cur_state != P_DATA);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= P_WC;
      entries.valid <= 1'b0;
      lines_ok      <= '0;
      lines_bad     <= '0;
    end else begin
      if (entries.valid && entries.ready) begin
        entries.valid <= 1'b0;
      end
      if (grp_done) begin
        entries.valid <= 1'b1;
      end
      if (line_end) begin
        state <= P_WC;
        if (!line_skip) begin
          if (line_bad) begin
            lines_bad <= lines_bad + 1'b1;
          end else begin
            lines_ok <= lines_ok + 1'b1;
          end
        end
      end else if (xfer) begin
        unique case (cur_state)
          P_WC:    state <= P_ADR;
          P_ADR:   state <= P_DATA;
          default: state <= P_DATA;
        endcase
      end
    end
  end

  // Line fields, group buffer and entry payload
  always_ff @(posedge clk) begin
    if (xfer) begin
      sum <= sum_next;
    end
    if (xfer && !words.last) begin
      unique case (cur_state)
        P_WC: begin
          wc    <= words.word;
          ndata <= '0;
          slot  <= '0;
        end
        P_ADR: begin
          addr <= (words.kind == REC_D) ? CRAM_ADDR_W'(words.word[DRAM_ADDR_W-1:0])
                                        : words.word[CRAM_ADDR_W-1:0];
        end
        default: begin
          ndata <= ndata + 1'b1;
          if (packs) begin
            entries.data[slot] <= words.word;
            if (slot == grp_last) begin
              slot            <= '0;
              entries.addr    <= addr;
              entries.is_dram <= (words.kind == REC_D);
              addr            <= addr_next;
            end else begin
              slot <= slot + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // Entry stays offered and unchanged until the writer takes it
  a_entry_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (entries.valid && !entries.ready) |=> (entries.valid && $stable(entries.addr)));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fe_loader -f fe_loader.f -Mdir obj_dir -o sim_fe_loader; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_fe_loader > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
